//--- hw/pmp_params.svh
// PMP parameters for the entry count and the CSR base addresses
`ifndef PMP_PARAMS_SVH
`define PMP_PARAMS_SVH

// Number of PMP entries, a multiple of 4 (4, 8 or 16)
`define PMP_ENTRIES 16

// Machine-mode CSR addresses
`define PMP_CFG_BASE  12'h3A0  // pmpcfg0..pmpcfg3
`define PMP_ADDR_BASE 12'h3B0  // pmpaddr0..pmpaddr15

`endif

//--- hw/pmp_pkg.sv
// PMP package with the shared enums and packed structs
`default_nettype none

package pmp_pkg;

  // Address matching mode of one entry
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_a_e;

  // One pmpcfg byte in spec bit order
  typedef struct packed {
    logic       L;
    logic [1:0] reserved;
    pmp_a_e     A;
    logic       X;
    logic       W;
    logic       R;
  } pmp_cfg_t;

  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    ACC_LOAD  = 2'b00,
    ACC_STORE = 2'b01,
    ACC_FETCH = 2'b10
  } access_e;

  typedef struct packed {
    logic [31:0] addr;  // Byte address
    access_e     kind;
    priv_e       priv;
    logic        mprv;
    priv_e       mpp;
  } pmp_req_t;

  typedef struct packed {
    pmp_req_t req;
    logic     hit;      // Some entry matched
    pmp_cfg_t cfg;      // Config of the winning entry
  } pmp_match_t;

  typedef struct packed {
    logic [31:0] addr;
    access_e     kind;
    logic        fault;
  } pmp_rsp_t;

endpackage

`default_nettype wire

//--- hw/pmp_csr_file.sv
// PMP CSR file holding pmpcfg and pmpaddr with WARL write filtering
`timescale 1ns/10ps
`default_nettype none
`include "pmp_params.svh"

module pmp_csr_file (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  logic                                 i_csr_we,
  input  logic [11:0]                          i_csr_addr,
  input  logic [31:0]                          i_csr_wdata,
  output logic [31:0]                          o_csr_rdata,
  output logic                                 o_csr_ack,
  output pmp_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0] o_cfg,
  output logic [`PMP_ENTRIES-1:0][31:0]        o_addr
);
  import pmp_pkg::*;

  localparam logic [11:0] CFG_BASE  = `PMP_CFG_BASE;
  localparam logic [11:0] ADDR_BASE = `PMP_ADDR_BASE;
  localparam int          N         = `PMP_ENTRIES;

  pmp_cfg_t [N-1:0]   cfg_q, cfg_d;
  logic [N-1:0][31:0] addr_q, addr_d;
  logic               cfg_hit;
  logic               addr_hit;

  assign cfg_hit  = (i_csr_addr[11:2] == CFG_BASE[11:2]);   // 0x3A0-0x3A3
  assign addr_hit = (i_csr_addr[11:4] == ADDR_BASE[11:4]);  // 0x3B0-0x3BF

  // Next state from a CSR write
  always_comb begin
    pmp_cfg_t new_cfg;
    int       e;
    int       a;
    logic     locked;
    cfg_d   = cfg_q;
    addr_d  = addr_q;
    new_cfg = '0;
    locked  = 1'b0;
    e       = 0;
    a       = int'(i_csr_addr[3:0]);
    if (i_csr_we && cfg_hit) begin
      for (int b = 0; b < 4; b++) begin
        e       = int'(i_csr_addr[1:0]) * 4 + b;
        new_cfg = pmp_cfg_t'(i_csr_wdata[8*b +: 8]);
        new_cfg.reserved = 2'b00;
        if (!new_cfg.R) begin
          new_cfg.W = 1'b0;  // W without R is reserved
        end
        // Locked bytes keep their value
        if (e < N && !cfg_q[e].L) begin
          cfg_d[e] = new_cfg;
        end
      end
    end
    if (i_csr_we && addr_hit && a < N) begin
      locked = cfg_q[a].L;
      // A locked TOR entry above also owns this address as its base
      if (a + 1 < N && cfg_q[a+1].L && cfg_q[a+1].A == TOR) begin
        locked = 1'b1;
      end
      if (!locked) begin
        addr_d[a] = i_csr_wdata;  // Stored unchanged, grain is 4 bytes
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  // Read-back, unimplemented entries read as zero
  always_comb begin
    int e;
    int a;
    o_csr_rdata = '0;
    o_csr_ack   = 1'b0;
    e           = 0;
    a           = int'(i_csr_addr[3:0]);
    if (cfg_hit) begin
      o_csr_ack = 1'b1;
      for (int b = 0; b < 4; b++) begin
        e = int'(i_csr_addr[1:0]) * 4 + b;
        if (e < N) begin
          o_csr_rdata[8*b +: 8] = cfg_q[e];
        end
      end
    end else if (addr_hit) begin
      o_csr_ack = 1'b1;
      if (a < N) begin
        o_csr_rdata = addr_q[a];
      end
    end
  end

  assign o_cfg  = cfg_q;
  assign o_addr = addr_q;

endmodule

`default_nettype wire

//--- hw/pmp_region_match.sv
// PMP region matcher for one entry in TOR, NA4 or NAPOT mode
`timescale 1ns/10ps
`default_nettype none

module pmp_region_match (
  input  logic [31:0]       i_addr,          // Word address
  input  pmp_pkg::pmp_cfg_t i_cfg,
  input  logic [31:0]       i_pmpaddr,
  input  logic [31:0]       i_prev_pmpaddr,  // Zero for entry 0
  output logic              o_match
);
  import pmp_pkg::*;

  logic [31:0] napot_care;

  // Trailing ones plus the next bit are the region bits, the rest must compare
  assign napot_care = ~(i_pmpaddr ^ (i_pmpaddr + 32'd1));

  always_comb begin
    o_match = 1'b0;
    case (i_cfg.A)
      OFF:   o_match = 1'b0;
      TOR:   o_match = (i_addr >= i_prev_pmpaddr) && (i_addr < i_pmpaddr);
      NA4:   o_match = (i_addr == i_pmpaddr);
      NAPOT: o_match = ((i_addr ^ i_pmpaddr) & napot_care) == 32'd0;
      default: o_match = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/pmp_pipe_reg.sv
// One-entry valid/ready pipeline register for any payload type
`timescale 1ns/10ps
`default_nettype none

module pmp_pipe_reg #(
  parameter type T = logic
) (
  input  logic CLK,
  input  logic nRST,
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  logic full;
  T     data_q;

  // Loads when empty or when the held item leaves this cycle
  assign o_ready = !full || i_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (o_ready) begin
      full <= i_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (o_ready && i_valid) begin
      data_q <= i_data;
    end
  end

  assign o_valid = full;
  assign o_data  = data_q;

endmodule

`default_nettype wire

//--- hw/pmp_match_stage.sv
// PMP match stage finding the lowest-numbered hit over all entries
`timescale 1ns/10ps
`default_nettype none
`include "pmp_params.svh"

module pmp_match_stage (
  input  logic                                 CLK,
  input  logic                                 nRST,
  input  logic                                 i_valid,
  input  pmp_pkg::pmp_req_t                    i_req,
  output logic                                 o_ready,
  input  pmp_pkg::pmp_cfg_t [`PMP_ENTRIES-1:0] i_cfg,
  input  logic [`PMP_ENTRIES-1:0][31:0]        i_addr,
  output logic                                 o_valid,
  output pmp_pkg::pmp_match_t                  o_match,
  input  logic                                 i_ready
);
  import pmp_pkg::*;

  localparam int N = `PMP_ENTRIES;

  logic [31:0]        word_addr;
  logic [N-1:0][31:0] prev_addr;
  logic [N-1:0]       region_hit;
  pmp_match_t         match_d;

  assign word_addr = {2'b00, i_req.addr[31:2]};
  assign prev_addr = {i_addr[N-2:0], 32'd0};  // TOR base of entry 0 is zero

  for (genvar g = 0; g < N; g++) begin : g_region
    pmp_region_match pmp_region_match_i (
      .i_addr         (word_addr),
      .i_cfg          (i_cfg[g]),
      .i_pmpaddr      (i_addr[g]),
      .i_prev_pmpaddr (prev_addr[g]),
      .o_match        (region_hit[g])
    );
  end

  // Scan from the top so the lowest index is written last
  always_comb begin
    match_d.req = i_req;
    match_d.hit = 1'b0;
    match_d.cfg = '0;
    for (int k = N - 1; k >= 0; k--) begin
      if (region_hit[k]) begin
        match_d.hit = 1'b1;
        match_d.cfg = i_cfg[k];
      end
    end
  end

  pmp_pipe_reg #(.T(pmp_match_t)) pmp_pipe_reg_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_valid (i_valid),
    .i_data  (match_d),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_match),
    .i_ready (i_ready)
  );

endmodule

`default_nettype wire

//--- hw/pmp_decide_stage.sv
// PMP decide stage applying the privilege and permission rules
`timescale 1ns/10ps
`default_nettype none

module pmp_decide_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                i_valid,
  input  pmp_pkg::pmp_match_t i_match,
  output logic                o_ready,
  output logic                o_valid,
  output pmp_pkg::pmp_rsp_t   o_rsp,
  input  logic                i_ready
);
  import pmp_pkg::*;

  priv_e    eff_priv;
  logic     perm;
  pmp_rsp_t rsp_d;

  // MPRV applies to data accesses only
  always_comb begin
    eff_priv = i_match.req.priv;
    if (i_match.req.mprv &&
        (i_match.req.kind == ACC_LOAD || i_match.req.kind == ACC_STORE)) begin
      eff_priv = i_match.req.mpp;
    end
  end

  always_comb begin
    case (i_match.req.kind)
      ACC_LOAD:  perm = i_match.cfg.R;
      ACC_STORE: perm = i_match.cfg.W;
      ACC_FETCH: perm = i_match.cfg.X;
      default:   perm = 1'b0;
    endcase
  end

  always_comb begin
    rsp_d.addr = i_match.req.addr;
    rsp_d.kind = i_match.req.kind;
    if (eff_priv != M_MODE) begin
      rsp_d.fault = !i_match.hit || !perm;               // Miss faults below M
    end else begin
      rsp_d.fault = i_match.hit && i_match.cfg.L && !perm;  // Only locked entries bind M
    end
  end

  pmp_pipe_reg #(.T(pmp_rsp_t)) pmp_pipe_reg_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_valid (i_valid),
    .i_data  (rsp_d),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_data  (o_rsp),
    .i_ready (i_ready)
  );

endmodule

`default_nettype wire

//--- hw/pmp_top.sv
// PMP unit top level joining the CSR file and the two pipeline stages
`timescale 1ns/10ps
`default_nettype none
`include "pmp_params.svh"

module pmp_top (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              i_csr_we,
  input  logic [11:0]       i_csr_addr,
  input  logic [31:0]       i_csr_wdata,
  output logic [31:0]       o_csr_rdata,
  output logic              o_csr_ack,
  input  logic              i_req_valid,
  input  pmp_pkg::pmp_req_t i_req,
  output logic              o_req_ready,
  output logic              o_rsp_valid,
  output pmp_pkg::pmp_rsp_t o_rsp,
  input  logic              i_rsp_ready
);
  import pmp_pkg::*;

  pmp_cfg_t [`PMP_ENTRIES-1:0]   cfg;
  logic [`PMP_ENTRIES-1:0][31:0] addr;
  logic                          m_valid;
  logic                          m_ready;
  pmp_match_t                    m_match;

  pmp_csr_file pmp_csr_file_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr_we    (i_csr_we),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_csr_ack   (o_csr_ack),
    .o_cfg       (cfg),
    .o_addr      (addr)
  );

  pmp_match_stage pmp_match_stage_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_valid (i_req_valid),
    .i_req   (i_req),
    .o_ready (o_req_ready),
    .i_cfg   (cfg),
    .i_addr  (addr),
    .o_valid (m_valid),
    .o_match (m_match),
    .i_ready (m_ready)
  );

  pmp_decide_stage pmp_decide_stage_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .i_valid (m_valid),
    .i_match (m_match),
    .o_ready (m_ready),
    .o_valid (o_rsp_valid),
    .o_rsp   (o_rsp),
    .i_ready (i_rsp_ready)
  );

endmodule

`default_nettype wire

//--- tests/pmp_chk.sv
// PMP checker with assertions on the response handshake, reset state and CSR decode
`timescale 1ns/10ps
`default_nettype none
`include "pmp_params.svh"

module pmp_chk (
  input logic              CLK,
  input logic              nRST,
  input logic [11:0]       i_csr_addr,
  input logic              o_csr_ack,
  input logic              o_rsp_valid,
  input pmp_pkg::pmp_rsp_t o_rsp,
  input logic              i_rsp_ready
);

  localparam logic [11:0] CFG_BASE  = `PMP_CFG_BASE;
  localparam logic [11:0] ADDR_BASE = `PMP_ADDR_BASE;

  int   fail_count = 0;
  logic pmp_csr;

  // Four pmpcfg and sixteen pmpaddr CSRs
  assign pmp_csr = (i_csr_addr >= CFG_BASE && i_csr_addr <= CFG_BASE + 12'd3) ||
                   (i_csr_addr >= ADDR_BASE && i_csr_addr <= ADDR_BASE + 12'd15);

  // A stalled response keeps its valid and payload
  rsp_hold: assert property (@(posedge CLK) disable iff (!nRST)
      o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else begin
      fail_count = fail_count + 1;
      $error("o_rsp changed or dropped while stalled");
    end

  rsp_reset: assert property (@(posedge CLK) !nRST |-> !o_rsp_valid)
    else begin
      fail_count = fail_count + 1;
      $error("o_rsp_valid high during reset");
    end

  ack_decode: assert property (@(posedge CLK) !pmp_csr |-> !o_csr_ack)
    else begin
      fail_count = fail_count + 1;
      $error("o_csr_ack high for a non-PMP CSR address");
    end

endmodule

bind pmp_top pmp_chk pmp_chk_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .i_csr_addr  (i_csr_addr),
  .o_csr_ack   (o_csr_ack),
  .o_rsp_valid (o_rsp_valid),
  .o_rsp       (o_rsp),
  .i_rsp_ready (i_rsp_ready)
);

`default_nettype wire

//--- tests/pmp_tb.sv
// PMP testbench covering CSR WARL rules, locking, region modes, privilege and a stalled stream
`timescale 1ns/10ps
`default_nettype none
`include "pmp_params.svh"

module pmp_tb;
  import pmp_pkg::*;

  localparam int          N             = `PMP_ENTRIES;
  localparam logic [11:0] CFG_BASE      = `PMP_CFG_BASE;
  localparam logic [11:0] ADDR_BASE     = `PMP_ADDR_BASE;
  localparam int          REQ_TIMEOUT   = 100;
  localparam int          DRAIN_TIMEOUT = 500;

  logic        CLK = 1'b0;
  logic        nRST;
  logic        i_csr_we;
  logic [11:0] i_csr_addr;
  logic [31:0] i_csr_wdata;
  logic [31:0] o_csr_rdata;
  logic        o_csr_ack;
  logic        i_req_valid;
  pmp_req_t    i_req;
  logic        o_req_ready;
  logic        o_rsp_valid;
  pmp_rsp_t    o_rsp;
  logic        i_rsp_ready;

  pmp_cfg_t    sh_cfg [N];   // Shadow of the CSR state
  logic [31:0] sh_addr [N];
  pmp_rsp_t    exp_q [$];
  int          acc_q [$];    // Acceptance edge or -1 when latency is not checked
  int          cyc = 0;
  logic [31:0] rng;
  logic        stall_mode;
  logic        lat_check;
  string       test_name;

  pmp_top pmp_top_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_csr_we    (i_csr_we),
    .i_csr_addr  (i_csr_addr),
    .i_csr_wdata (i_csr_wdata),
    .o_csr_rdata (o_csr_rdata),
    .o_csr_ack   (o_csr_ack),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready)
  );

  always #5 CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic string rsp_text(input pmp_rsp_t r);
    return $sformatf("addr=%08h kind=%0d fault=%0b", r.addr, r.kind, r.fault);
  endfunction

  task automatic check_csr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_rsp(input string name, input pmp_rsp_t exp, input pmp_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %s actual %s", name, rsp_text(exp),
                          rsp_text(act)));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic get_rand(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  // WARL rules applied to the shadow copy
  function automatic void shadow_write(input logic [11:0] a, input logic [31:0] d);
    pmp_cfg_t c;
    int       idx;
    if (a[11:2] == CFG_BASE[11:2]) begin
      for (int b = 0; b < 4; b++) begin
        idx        = int'(a[1:0]) * 4 + b;
        c          = pmp_cfg_t'(d[8*b +: 8]);
        c.reserved = 2'b00;
        c.W        = c.W & c.R;
        if (idx < N && !sh_cfg[idx].L) sh_cfg[idx] = c;
      end
    end else if (a[11:4] == ADDR_BASE[11:4]) begin
      idx = int'(a[3:0]);
      if (idx < N && !sh_cfg[idx].L &&
          !(idx + 1 < N && sh_cfg[idx+1].L && sh_cfg[idx+1].A == TOR)) begin
        sh_addr[idx] = d;
      end
    end
  endfunction

  function automatic logic [31:0] shadow_read(input logic [11:0] a);
    logic [31:0] v;
    v = '0;
    if (a[11:2] == CFG_BASE[11:2]) begin
      for (int b = 0; b < 4; b++) v[8*b +: 8] = sh_cfg[int'(a[1:0]) * 4 + b];
    end else if (a[11:4] == ADDR_BASE[11:4]) begin
      v = sh_addr[int'(a[3:0])];
    end
    return v;
  endfunction

  // NAPOT region covers 2^(trailing ones + 1) words
  function automatic logic napot_contains(input logic [31:0] word, input logic [31:0] pa);
    int ones;
    ones = 0;
    for (int b = 0; b < 32; b++) begin
      if (pa[b] && ones == b) ones++;
    end
    return (word >> (ones + 1)) == (pa >> (ones + 1));
  endfunction

  function automatic logic expected_fault(input pmp_req_t r);
    logic [31:0] word;
    logic [31:0] lower;
    logic        hit;
    logic        found;
    logic        allowed;
    pmp_cfg_t    win;
    priv_e       eff;
    word  = r.addr >> 2;
    found = 1'b0;
    win   = '0;
    for (int i = 0; i < N; i++) begin
      lower = 32'd0;
      if (i > 0) lower = sh_addr[i-1];
      case (sh_cfg[i].A)
        TOR:     hit = (word >= lower) && (word < sh_addr[i]);
        NA4:     hit = (word == sh_addr[i]);
        NAPOT:   hit = napot_contains(word, sh_addr[i]);
        default: hit = 1'b0;
      endcase
      if (hit && !found) begin  // Lowest index wins
        found = 1'b1;
        win   = sh_cfg[i];
      end
    end
    eff = (r.mprv && r.kind != ACC_FETCH) ? r.mpp : r.priv;
    case (r.kind)
      ACC_STORE: allowed = win.W;
      ACC_FETCH: allowed = win.X;
      default:   allowed = win.R;
    endcase
    if (eff == M_MODE) return found && win.L && !allowed;
    return !found || !allowed;
  endfunction

  // Responses are compared before new acceptances are queued
  always @(negedge CLK) begin : monitor
    pmp_rsp_t exp_rsp;
    int       acc;
    if (nRST) begin
      if (o_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a response came out with no request outstanding");
        end else begin
          exp_rsp = exp_q.pop_front();
          acc     = acc_q.pop_front();
          check_rsp(test_name, exp_rsp, o_rsp);
          if (acc >= 0 && cyc - acc != 2) begin
            abort_run($sformatf("ERROR %s: latency expected 2 actual %0d", test_name, cyc - acc));
          end
        end
      end
      if (i_req_valid && o_req_ready) begin
        exp_rsp.addr  = i_req.addr;
        exp_rsp.kind  = i_req.kind;
        exp_rsp.fault = expected_fault(i_req);
        exp_q.push_back(exp_rsp);
        acc_q.push_back(lat_check ? cyc : -1);
      end
    end
  end

  task automatic tick();
    logic [31:0] v;
    @(posedge CLK);
    #1;
    if (stall_mode) begin
      get_rand(v);
      i_rsp_ready = (v[1:0] != 2'b00);
    end
  endtask

  task automatic apply_reset();
    nRST = 1'b0;
    for (int i = 0; i < N; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    if (!o_req_ready || o_rsp_valid) abort_run("request and response paths not idle after reset");
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    i_csr_we    = 1'b1;
    i_csr_addr  = a;
    i_csr_wdata = d;
    @(posedge CLK);
    shadow_write(a, d);
    #1;
    i_csr_we = 1'b0;
  endtask

  task automatic csr_read_check(input logic [11:0] a, input logic ack, input logic [31:0] exp);
    i_csr_we   = 1'b0;
    i_csr_addr = a;
    @(negedge CLK);
    check_csr($sformatf("%s ack %03h", test_name, a), {31'd0, ack}, {31'd0, o_csr_ack});
    check_csr($sformatf("%s read %03h", test_name, a), exp, o_csr_rdata);
    @(posedge CLK);
    #1;
  endtask

  task automatic send_req(input pmp_req_t r);
    int   waited;
    logic taken;
    waited      = 0;
    taken       = 1'b0;
    i_req_valid = 1'b1;
    i_req       = r;
    while (!taken) begin
      @(negedge CLK);
      taken = o_req_ready;
      tick();
      waited++;
      if (waited > REQ_TIMEOUT) abort_run("timed out waiting for o_req_ready");
    end
    i_req_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited      = 0;
    stall_mode  = 1'b0;
    i_rsp_ready = 1'b1;
    while (exp_q.size() != 0) begin
      tick();
      waited++;
      if (waited > DRAIN_TIMEOUT) abort_run("timed out waiting for outstanding responses");
    end
    repeat (3) tick();  // Catch stray responses
  endtask

  function automatic pmp_req_t make_req(input logic [31:0] addr, input access_e kind,
                                        input priv_e priv, input logic mprv, input priv_e mpp);
    pmp_req_t r;
    r.addr = addr;
    r.kind = kind;
    r.priv = priv;
    r.mprv = mprv;
    r.mpp  = mpp;
    return r;
  endfunction

  function automatic priv_e pick_priv(input logic [1:0] v);
    return (v == 2'd0) ? U_MODE : (v == 2'd1) ? S_MODE : M_MODE;
  endfunction

  task automatic rand_req(output pmp_req_t r);
    logic [31:0] a;
    logic [31:0] v;
    get_rand(a);
    get_rand(v);
    a = a[31] ? {a[30:0], 1'b0} : {18'd0, a[13:0]};  // Mostly near the regions
    r = make_req(a, (v[1:0] == 2'd1) ? ACC_STORE : (v[1:0] == 2'd2) ? ACC_FETCH : ACC_LOAD,
                 pick_priv(v[3:2]), v[4], pick_priv(v[6:5]));
  endtask

  initial begin
    logic [31:0] probes [13];
    access_e     kinds [3];
    logic [31:0] v;
    logic [11:0] a;
    pmp_req_t    r;
    probes = '{32'h000, 32'h2FC, 32'h300, 32'h3FC, 32'h400, 32'h404, 32'h5FC,
               32'h600, 32'h604, 32'h7FC, 32'h800, 32'h804, 32'h808};
    kinds  = '{ACC_LOAD, ACC_STORE, ACC_FETCH};
    rng         = 32'h4a811b7f;
    nRST        = 1'b1;
    i_csr_we    = 1'b0;
    i_csr_addr  = '0;
    i_csr_wdata = '0;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rsp_ready = 1'b1;
    stall_mode  = 1'b0;
    lat_check   = 1'b0;
    test_name   = "reset";
    #1;
    apply_reset();

    test_name = "warl";
    csr_write(CFG_BASE + 12'd1, 32'h3A7B6602);
    csr_read_check(CFG_BASE + 12'd1, 1'b1, 32'h181B0400);  // Reserved bits zero and W without R cleared
    csr_read_check(12'h3C0, 1'b0, 32'd0);
    csr_read_check(12'h39F, 1'b0, 32'd0);
    csr_read_check(12'h3A4, 1'b0, 32'd0);
    repeat (2) begin
      for (int j = 0; j < 20; j++) begin
        a = (j < 4) ? CFG_BASE + 12'(j) : ADDR_BASE + 12'(j - 4);
        get_rand(v);
        csr_write(a, v);
        csr_read_check(a, 1'b1, shadow_read(a));
      end
    end

    apply_reset();
    test_name = "lock";
    csr_write(ADDR_BASE + 12'd9, 32'h00001234);
    csr_write(CFG_BASE + 12'd2, 32'h00009100);   // Entry 9 NA4, R, locked
    csr_write(CFG_BASE + 12'd2, 32'h00000000);
    csr_read_check(CFG_BASE + 12'd2, 1'b1, 32'h00009100);
    csr_write(ADDR_BASE + 12'd9, 32'h00005678);
    csr_read_check(ADDR_BASE + 12'd9, 1'b1, 32'h00001234);
    csr_write(ADDR_BASE + 12'd12, 32'h00000AAA);
    csr_write(CFG_BASE + 12'd3, 32'h00008900);   // Entry 13 TOR locked
    csr_write(ADDR_BASE + 12'd12, 32'h00000BBB);
    csr_read_check(ADDR_BASE + 12'd12, 1'b1, 32'h00000AAA);
    csr_write(CFG_BASE + 12'd2, 32'h08000000);   // Entry 11 TOR unlocked
    csr_write(ADDR_BASE + 12'd10, 32'h00000CCC);
    csr_read_check(ADDR_BASE + 12'd10, 1'b1, 32'h00000CCC);
    csr_read_check(CFG_BASE + 12'd2, 1'b1, 32'h08009100);

    apply_reset();
    test_name = "modes";
    csr_write(ADDR_BASE + 12'd0, 32'h100);  // NA4 at 0x400
    csr_write(ADDR_BASE + 12'd1, 32'h0C0);  // TOR base 0x300
    csr_write(ADDR_BASE + 12'd2, 32'h180);  // TOR top 0x600
    csr_write(ADDR_BASE + 12'd3, 32'h17F);  // NAPOT 0x400..0x7FF
    csr_write(ADDR_BASE + 12'd4, 32'h200);  // NAPOT 0x800..0x807
    csr_write(CFG_BASE, 32'h1C0B0011);
    csr_write(CFG_BASE + 12'd1, 32'h0000001F);
    lat_check = 1'b1;
    for (int i = 0; i < 13; i++) begin
      for (int k = 0; k < 3; k++) send_req(make_req(probes[i], kinds[k], U_MODE, 1'b0, U_MODE));
    end
    drain();

    test_name = "priv";
    csr_write(ADDR_BASE + 12'd8, 32'h5FF);  // NAPOT 0x1000..0x1FFF
    csr_write(ADDR_BASE + 12'd9, 32'h800);  // NA4 at 0x2000
    csr_write(CFG_BASE + 12'd2, 32'h00001099);
    send_req(make_req(32'h1000, ACC_STORE, M_MODE, 1'b0, U_MODE));  // Locked, no W
    send_req(make_req(32'h1000, ACC_LOAD,  M_MODE, 1'b0, U_MODE));
    send_req(make_req(32'h2000, ACC_STORE, M_MODE, 1'b0, U_MODE));
    send_req(make_req(32'h3000, ACC_FETCH, M_MODE, 1'b0, U_MODE));
    send_req(make_req(32'h3000, ACC_LOAD,  U_MODE, 1'b0, U_MODE));  // Miss below M
    send_req(make_req(32'h1000, ACC_LOAD,  S_MODE, 1'b0, U_MODE));
    send_req(make_req(32'h2000, ACC_LOAD,  M_MODE, 1'b1, U_MODE));
    send_req(make_req(32'h3000, ACC_LOAD,  M_MODE, 1'b1, U_MODE));
    send_req(make_req(32'h3000, ACC_FETCH, M_MODE, 1'b1, U_MODE));  // MPRV not for fetch
    send_req(make_req(32'h1000, ACC_STORE, M_MODE, 1'b1, M_MODE));
    drain();

    test_name = "stream";
    repeat (50) begin
      rand_req(r);
      send_req(r);
    end
    drain();

    test_name  = "backpressure";
    lat_check  = 1'b0;
    stall_mode = 1'b1;
    repeat (200) begin
      rand_req(r);
      get_rand(v);
      if (v[3:0] == 4'd0) tick();  // Occasional idle gap
      send_req(r);
    end
    drain();

    if (pmp_top_i.pmp_chk_i.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run($sformatf("the checker reported %0d assertion failures",
                          pmp_top_i.pmp_chk_i.fail_count));
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/pmp_pkg.sv
hw/pmp_csr_file.sv
hw/pmp_region_match.sv
hw/pmp_pipe_reg.sv
hw/pmp_match_stage.sv
hw/pmp_decide_stage.sv
hw/pmp_top.sv
tests/pmp_chk.sv
tests/pmp_tb.sv

//--- Bender.yml
package:
  name: pmp

sources:
  - include_dirs:
      - hw
    files:
      - hw/pmp_pkg.sv
      - hw/pmp_csr_file.sv
      - hw/pmp_region_match.sv
      - hw/pmp_pipe_reg.sv
      - hw/pmp_match_stage.sv
      - hw/pmp_decide_stage.sv
      - hw/pmp_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/pmp_chk.sv
      - tests/pmp_tb.sv
